//--- common/periph_config.svh
// ------------------------------
// Bus widths, register indices
// and reset values
// ------------------------------
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

`define PERIPH_DATA_W        32
`define PERIPH_ADDR_W        11
`define PERIPH_REGION_BIT    10             // Host address bit that picks RAM
`define PERIPH_RAM_AW        8
`define PERIPH_BAUD_W        16
`define PERIPH_BAUD_RESET    16'd16         // Cycles per serial bit after reset
`define PERIPH_BYTE_W        8
`define PERIPH_DIP_W         16
`define PERIPH_IRQ_W         3
`define PERIPH_REG_IDX_W     4
`define PERIPH_UNMAPPED_WORD 32'hDEADBEEF

`define REG_LED       4'd0
`define REG_BAUD      4'd1
`define REG_TX        4'd2
`define REG_RX_ACK    4'd3
`define REG_IRQ_EN    4'd4
`define REG_UART_STAT 4'd5
`define REG_IRQ_STAT  4'd6
`define REG_DIP       4'd7

`endif

//--- common/periph_pkg.sv
// ------------------------------
// Shared vector types, bus and
// UART structs, FSM encodings
// ------------------------------
`default_nettype none
`include "periph_config.svh"

package periph_pkg;

   typedef logic [`PERIPH_DATA_W-1:0] word_t;
   typedef logic [`PERIPH_ADDR_W-1:0] host_addr_t;
   typedef logic [`PERIPH_RAM_AW-1:0] ram_addr_t;
   typedef logic [`PERIPH_BYTE_W-1:0] byte_t;
   typedef logic [`PERIPH_BAUD_W-1:0] baud_t;     // Clock cycles per bit
   typedef logic [`PERIPH_DIP_W-1:0]  dip_t;
   typedef logic [`PERIPH_IRQ_W-1:0]  irq_vec_t;  // {tx idle, rx error, rx done}

   typedef struct packed {
      logic       en;
      logic       we;
      host_addr_t addr;
      word_t      wdata;
   } host_req_t;

   typedef struct packed {
      logic  tx_start;                            // One-cycle pulse
      byte_t tx_byte;
      logic  rx_ack;                              // One-cycle pulse
      baud_t baud;
   } uart_cmd_t;

   // Read back right-aligned, rx_byte in the low byte
   typedef struct packed {
      logic  is_recv;
      logic  is_trans;
      logic  recv_err;
      logic  received;
      byte_t rx_byte;
   } uart_stat_t;

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

`default_nettype wire

//--- logic/host_decode.sv
// ------------------------------
// Host region decoder and read
// return select
// ------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "periph_config.svh"

module host_decode import periph_pkg::*;
(
   input  wire       msoc_clk,
   input  wire       rstn,
   input  host_req_t host_i,
   output host_req_t reg_req_o,
   output host_req_t ram_req_o,
   input  word_t     reg_rdata_i,
   input  word_t     ram_rdata_i,
   output word_t     host_rdata_o
);

   logic region;                                  // 1 selects the transfer RAM
   logic region_q;                                // Region of the access in flight

   assign region = host_i.addr[`PERIPH_REGION_BIT];

   always_comb
   begin
      reg_req_o    = host_i;
      reg_req_o.en = host_i.en & ~region;
      ram_req_o    = host_i;
      ram_req_o.en = host_i.en & region;
   end

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
         region_q <= 1'b0;
      else if (host_i.en)
         region_q <= region;
   end

   // Both sides register their read word, so pick by last cycle's region
   assign host_rdata_o = region_q ? ram_rdata_i : reg_rdata_i;

endmodule

`default_nettype wire

//--- logic/ctrl_regs.sv
// ------------------------------
// Control register bank, UART
// commands and interrupt logic
// ------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "periph_config.svh"

module ctrl_regs import periph_pkg::*;
(
   input  wire        msoc_clk,
   input  wire        rstn,
   input  host_req_t  reg_req_i,
   output word_t      rdata_o,
   input  dip_t       dip_i,
   output byte_t      led_o,
   input  uart_stat_t uart_stat_i,
   output uart_cmd_t  uart_cmd_o,
   output logic       irq_o
);

   logic [`PERIPH_REG_IDX_W-1:0] idx;
   logic     wr;
   byte_t    led_q;
   baud_t    baud_q;
   byte_t    tx_byte_q;
   logic     tx_start_q;
   logic     rx_ack_q;
   irq_vec_t irq_en_q;
   irq_vec_t irq_stat_q;
   irq_vec_t irq_now;
   logic     irq_q;
   dip_t     dip_q;
   word_t    rd_word;
   word_t    rdata_q;

   assign idx = reg_req_i.addr[`PERIPH_REG_IDX_W-1:0];
   assign wr  = reg_req_i.en & reg_req_i.we;

   // Bit 2 is transmitter idle, not busy
   assign irq_now = {~uart_stat_i.is_trans, uart_stat_i.recv_err, uart_stat_i.received};

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         led_q      <= '0;
         baud_q     <= `PERIPH_BAUD_RESET;
         tx_start_q <= 1'b0;
         rx_ack_q   <= 1'b0;
         irq_en_q   <= '0;
         irq_stat_q <= '0;
         irq_q      <= 1'b0;
         dip_q      <= '0;
      end
      else
      begin
         tx_start_q <= 1'b0;                      // Pulses last one cycle
         rx_ack_q   <= 1'b0;
         dip_q      <= dip_i;
         irq_stat_q <= irq_now;
         irq_q      <= |(irq_stat_q & irq_en_q);
         if (wr)
         begin
            case (idx)
               `REG_LED:    led_q      <= reg_req_i.wdata[`PERIPH_BYTE_W-1:0];
               `REG_BAUD:   baud_q     <= reg_req_i.wdata[`PERIPH_BAUD_W-1:0];
               `REG_TX:     tx_start_q <= 1'b1;
               `REG_RX_ACK: rx_ack_q   <= 1'b1;
               `REG_IRQ_EN: irq_en_q   <= reg_req_i.wdata[`PERIPH_IRQ_W-1:0];
               default:     ;                     // Read-only or unmapped
            endcase
         end
      end
   end

   always_comb
   begin
      case (idx)
         `REG_LED:       rd_word = word_t'(led_q);
         `REG_BAUD:      rd_word = word_t'(baud_q);
         `REG_TX:        rd_word = word_t'(tx_byte_q);
         `REG_RX_ACK:    rd_word = '0;
         `REG_IRQ_EN:    rd_word = word_t'(irq_en_q);
         `REG_UART_STAT: rd_word = word_t'(uart_stat_i);
         `REG_IRQ_STAT:  rd_word = word_t'(irq_stat_q);
         `REG_DIP:       rd_word = word_t'(dip_q);
         default:        rd_word = `PERIPH_UNMAPPED_WORD;
      endcase
   end

   always_ff @(posedge msoc_clk)
   begin
      if (wr && idx == `REG_TX)
         tx_byte_q <= reg_req_i.wdata[`PERIPH_BYTE_W-1:0];
      if (reg_req_i.en)
         rdata_q <= rd_word;                      // Word returned next cycle
   end

   assign rdata_o    = rdata_q;
   assign led_o      = led_q;
   assign irq_o      = irq_q;
   assign uart_cmd_o = {tx_start_q, tx_byte_q, rx_ack_q, baud_q};

endmodule

`default_nettype wire

//--- logic/xfer_ram.sv
// ------------------------------
// Host transfer RAM, 256 words
// ------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "periph_config.svh"

module xfer_ram import periph_pkg::*;
(
   input  wire       msoc_clk,
   input  host_req_t ram_req_i,
   output word_t     rdata_o
);

   word_t     mem [(1 << `PERIPH_RAM_AW)];
   ram_addr_t idx;
   word_t     rdata_q;

   assign idx = ram_req_i.addr[`PERIPH_RAM_AW-1:0];

   always_ff @(posedge msoc_clk)
   begin
      if (ram_req_i.en)
      begin
         if (ram_req_i.we)
            mem[idx] <= ram_req_i.wdata;
         rdata_q <= mem[idx];                     // Old word on a write
      end
   end

   assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- uart/uart_tx.sv
// ------------------------------
// UART transmitter, 8N1
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module uart_tx import periph_pkg::*;
(
   input  wire       msoc_clk,
   input  wire       rstn,
   input  uart_cmd_t uart_cmd_i,
   output logic      tx_o,
   output logic      is_trans_o
);

   tx_state_e  state_q;
   baud_t      cnt_q;
   baud_t      reload;
   logic [2:0] bit_q;
   byte_t      shift_q;
   logic       tx_q;
   logic       tick;
   logic       load;
   logic       shift_en;

   assign reload   = uart_cmd_i.baud - 1'b1;
   assign tick     = (cnt_q == '0);
   assign load     = (state_q == TX_IDLE) && uart_cmd_i.tx_start;
   assign shift_en = tick && (state_q == TX_START || state_q == TX_DATA);

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         state_q <= TX_IDLE;
         cnt_q   <= '0;
         bit_q   <= '0;
         tx_q    <= 1'b1;
      end
      else
      begin
         if (!tick)
            cnt_q <= cnt_q - 1'b1;
         case (state_q)
            TX_IDLE:
               if (uart_cmd_i.tx_start)
               begin
                  state_q <= TX_START;
                  tx_q    <= 1'b0;                // Start bit
                  cnt_q   <= reload;
               end
            TX_START:
               if (tick)
               begin
                  state_q <= TX_DATA;
                  tx_q    <= shift_q[0];          // LSB first
                  bit_q   <= '0;
                  cnt_q   <= reload;
               end
            TX_DATA:
               if (tick)
               begin
                  cnt_q <= reload;
                  if (bit_q == 3'd7)
                  begin
                     state_q <= TX_STOP;
                     tx_q    <= 1'b1;
                  end
                  else
                  begin
                     bit_q <= bit_q + 1'b1;
                     tx_q  <= shift_q[0];
                  end
               end
            default:
               if (tick)
                  state_q <= TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (load)
         shift_q <= uart_cmd_i.tx_byte;
      else if (shift_en)
         shift_q <= shift_q >> 1;
   end

   assign tx_o       = tx_q;
   assign is_trans_o = (state_q != TX_IDLE);

endmodule

`default_nettype wire

//--- uart/uart_rx.sv
// ------------------------------
// UART receiver with majority
// input filter
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module uart_rx import periph_pkg::*;
(
   input  wire        msoc_clk,
   input  wire        rstn,
   input  wire        rx_i,
   input  uart_cmd_t  uart_cmd_i,
   output uart_stat_t stat_o
);

   logic [2:0] samp_q;
   logic       maj;
   logic       maj_q;
   logic       maj_prev_q;
   logic       start_edge;
   rx_state_e  state_q;
   baud_t      cnt_q;
   baud_t      reload;
   baud_t      half;
   logic       tick;
   logic [2:0] bit_q;
   byte_t      data_q;
   byte_t      rx_byte_q;
   logic       received_q;
   logic       recv_err_q;

   // Two of three samples win, filters single-cycle glitches
   assign maj        = (samp_q[0] & samp_q[1]) | (samp_q[1] & samp_q[2]) |
                       (samp_q[0] & samp_q[2]);
   assign start_edge = maj_prev_q & ~maj_q;
   assign reload     = uart_cmd_i.baud - 1'b1;
   assign half       = (uart_cmd_i.baud >> 1) - 1'b1;
   assign tick       = (cnt_q == '0);

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         samp_q     <= '1;                        // Idle line is high
         maj_q      <= 1'b1;
         maj_prev_q <= 1'b1;
         state_q    <= RX_IDLE;
         cnt_q      <= '0;
         bit_q      <= '0;
         rx_byte_q  <= '0;
         received_q <= 1'b0;
         recv_err_q <= 1'b0;
      end
      else
      begin
         samp_q     <= {samp_q[1:0], rx_i};
         maj_q      <= maj;
         maj_prev_q <= maj_q;
         if (!tick)
            cnt_q <= cnt_q - 1'b1;
         if (uart_cmd_i.rx_ack)
         begin
            received_q <= 1'b0;
            recv_err_q <= 1'b0;
         end
         case (state_q)
            RX_IDLE:
               if (start_edge)
               begin
                  state_q <= RX_START;
                  cnt_q   <= half;                // Aim at mid start bit
               end
            RX_START:
               if (tick)
               begin
                  state_q <= maj_q ? RX_IDLE : RX_DATA;   // Glitch returns to idle
                  bit_q   <= '0;
                  cnt_q   <= reload;
               end
            RX_DATA:
               if (tick)
               begin
                  cnt_q <= reload;
                  bit_q <= bit_q + 1'b1;
                  if (bit_q == 3'd7)
                     state_q <= RX_STOP;
               end
            default:
               if (tick)
               begin
                  state_q   <= RX_IDLE;
                  rx_byte_q <= data_q;
                  if (maj_q)
                     received_q <= 1'b1;
                  else
                     recv_err_q <= 1'b1;          // Low stop bit
               end
         endcase
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (state_q == RX_DATA && tick)
         data_q <= {maj_q, data_q[7:1]};          // LSB arrives first
   end

   assign stat_o = {(state_q != RX_IDLE), 1'b0, recv_err_q, received_q, rx_byte_q};

endmodule

`default_nettype wire

//--- logic/periph_soc.sv
// ------------------------------
// Peripheral block top level
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module periph_soc import periph_pkg::*;
(
   input  wire        msoc_clk,
   input  wire        rstn,
   input  host_req_t  host_i,
   output word_t      host_rdata_o,
   output byte_t      led_o,
   input  dip_t       dip_i,
   input  wire        uart_rx_i,
   output logic       uart_tx_o,
   output logic       irq_o
);

   host_req_t  reg_req;
   host_req_t  ram_req;
   word_t      reg_rdata;
   word_t      ram_rdata;
   uart_cmd_t  uart_cmd;
   uart_stat_t rx_stat;                           // is_trans slot unused here
   uart_stat_t uart_stat;
   logic       tx_is_trans;

   // Merge transmitter busy flag into the receiver status
   assign uart_stat = {rx_stat.is_recv, tx_is_trans, rx_stat.recv_err,
                       rx_stat.received, rx_stat.rx_byte};

   host_decode host_decode_inst (
      .msoc_clk     (msoc_clk),
      .rstn         (rstn),
      .host_i       (host_i),
      .reg_req_o    (reg_req),
      .ram_req_o    (ram_req),
      .reg_rdata_i  (reg_rdata),
      .ram_rdata_i  (ram_rdata),
      .host_rdata_o (host_rdata_o)
   );

   ctrl_regs ctrl_regs_inst (
      .msoc_clk    (msoc_clk),
      .rstn        (rstn),
      .reg_req_i   (reg_req),
      .rdata_o     (reg_rdata),
      .dip_i       (dip_i),
      .led_o       (led_o),
      .uart_stat_i (uart_stat),
      .uart_cmd_o  (uart_cmd),
      .irq_o       (irq_o)
   );

   xfer_ram xfer_ram_inst (
      .msoc_clk  (msoc_clk),
      .ram_req_i (ram_req),
      .rdata_o   (ram_rdata)
   );

   uart_tx uart_tx_inst (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .uart_cmd_i (uart_cmd),
      .tx_o       (uart_tx_o),
      .is_trans_o (tx_is_trans)
   );

   uart_rx uart_rx_inst (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .rx_i       (uart_rx_i),
      .uart_cmd_i (uart_cmd),
      .stat_o     (rx_stat)
   );

endmodule

`default_nettype wire

//--- verification/periph_soc_assertions.sv
// ------------------------------
// Bound assertions for the
// peripheral top level
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module periph_soc_assertions import periph_pkg::*;
(
   input wire       msoc_clk,
   input wire       rstn,
   input host_req_t host_i,
   input word_t     host_rdata_i,
   input byte_t     led_i,
   input wire       uart_tx_i,
   input wire       irq_i,
   input wire       tx_is_trans_i
);

   // Outputs are cleared asynchronously while reset is held
   reset_outputs_zero: assert property (@(posedge msoc_clk)
      !rstn |-> (irq_i == 1'b0 && led_i == '0))
      else $error("irq_o or led_o not zero during reset");

   tx_idle_line_high: assert property (@(posedge msoc_clk) disable iff (!rstn)
      !tx_is_trans_i |-> uart_tx_i)
      else $error("uart_tx_o low while the transmitter is idle");

   // Read word is due one cycle after the access
   read_data_known: assert property (@(posedge msoc_clk) disable iff (!rstn)
      (host_i.en && !host_i.we) |=> !$isunknown(host_rdata_i))
      else $error("host_rdata_o has unknown bits after a read");

endmodule

bind periph_soc periph_soc_assertions periph_soc_assertions_inst (
   .msoc_clk      (msoc_clk),
   .rstn          (rstn),
   .host_i        (host_i),
   .host_rdata_i  (host_rdata_o),
   .led_i         (led_o),
   .uart_tx_i     (uart_tx_o),
   .irq_i         (irq_o),
   .tx_is_trans_i (tx_is_trans)
);

`default_nettype wire

//--- verification/tb_periph_soc.sv
// ------------------------------
// Testbench for the peripheral
// block, random stimulus checked
// against a register/RAM model
// ------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "periph_config.svh"

module tb_periph_soc import periph_pkg::*;
();

   localparam int BAUD_TEST      = 8;
   localparam int BUS_CYCLES     = 200;
   localparam int FRAMES         = 12;
   localparam int TIMEOUT_CYCLES = 2 * (BUS_CYCLES + FRAMES * 10 * BAUD_TEST);
   localparam int IRQ_WINDOW     = 12 * BAUD_TEST + 20;

   logic      msoc_clk;
   logic      rstn;
   host_req_t host_req;
   word_t     host_rdata;
   byte_t     led;
   dip_t      dip;
   logic      uart_rx;
   logic      uart_tx;
   logic      irq;
   logic      loopback;
   logic      drv_rx;                             // Serial line driven here

   integer    seed;
   int        cycle_cnt = 0;
   word_t     ram_model [256];
   ram_addr_t written_q [$];
   byte_t     led_shadow;
   baud_t     baud_shadow;
   irq_vec_t  irq_en_shadow;
   dip_t      dip_shadow;

   assign uart_rx = loopback ? uart_tx : drv_rx;

   periph_soc periph_soc_inst (
      .msoc_clk     (msoc_clk),
      .rstn         (rstn),
      .host_i       (host_req),
      .host_rdata_o (host_rdata),
      .led_o        (led),
      .dip_i        (dip),
      .uart_rx_i    (uart_rx),
      .uart_tx_o    (uart_tx),
      .irq_o        (irq)
   );

   always #2 msoc_clk = ~msoc_clk;

   always @(posedge msoc_clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
         abort_run($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp)
         abort_run($sformatf("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp));
   endtask

   task automatic check_byte(input string name, input byte_t got, input byte_t exp);
      if (got !== exp)
         abort_run($sformatf("CHECK FAILED %s: got 0x%02h expected 0x%02h", name, got, exp));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         abort_run($sformatf("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
   endtask

   // Called 1 ns after a rising edge, returns 1 ns after the edge that took the access
   task automatic bus_access(input logic we, input host_addr_t addr, input word_t wdata,
                             output word_t rdata);
      host_req.en    = 1'b1;
      host_req.we    = we;
      host_req.addr  = addr;
      host_req.wdata = wdata;
      @(posedge msoc_clk);
      #1;
      rdata       = host_rdata;
      host_req.en = 1'b0;
   endtask

   task automatic wait_cycles(input int n);
      repeat (n)
      begin
         @(posedge msoc_clk);
         #1;
      end
   endtask

   function automatic host_addr_t reg_addr(input logic [`PERIPH_REG_IDX_W-1:0] idx);
      logic [5:0] pad;                            // Upper bits are don't care
      pad = 6'($random(seed));
      return {1'b0, pad, idx};
   endfunction

   function automatic host_addr_t ram_addr(input ram_addr_t idx);
      logic [1:0] pad;
      pad = 2'($random(seed));
      return {1'b1, pad, idx};
   endfunction

   task automatic reg_write(input logic [`PERIPH_REG_IDX_W-1:0] idx, input word_t data);
      word_t unused;
      bus_access(1'b1, reg_addr(idx), data, unused);
   endtask

   task automatic reg_read(input logic [`PERIPH_REG_IDX_W-1:0] idx, output word_t data);
      bus_access(1'b0, reg_addr(idx), '0, data);
   endtask

   task automatic ram_write(input ram_addr_t idx, input word_t data);
      word_t unused;
      bus_access(1'b1, ram_addr(idx), data, unused);
   endtask

   task automatic ram_read(input ram_addr_t idx, output word_t data);
      bus_access(1'b0, ram_addr(idx), '0, data);
   endtask

   task automatic read_stat(output uart_stat_t stat);
      word_t rd;
      reg_read(`REG_UART_STAT, rd);
      stat = rd[$bits(uart_stat_t)-1:0];          // Right-aligned status word
   endtask

   task automatic wait_tx_idle();
      uart_stat_t stat;
      read_stat(stat);
      while (stat.is_trans)
         read_stat(stat);
   endtask

   task automatic wait_rx_flag(output uart_stat_t stat);
      read_stat(stat);
      while (!stat.received && !stat.recv_err)
         read_stat(stat);
   endtask

   task automatic transmit_byte(input byte_t b);
      wait_tx_idle();
      reg_write(`REG_TX, word_t'(b));
   endtask

   // Start bit, data LSB first, then the given stop bit
   task automatic drive_frame(input byte_t b, input logic stop_bit);
      logic [9:0] bits;
      bits = {stop_bit, b, 1'b0};
      for (int i = 0; i < 10; i++)
      begin
         drv_rx = bits[i];
         wait_cycles(BAUD_TEST);
      end
      drv_rx = 1'b1;
   endtask

   initial
   begin
      word_t      rd;
      word_t      val;
      uart_stat_t stat;
      byte_t      b;
      ram_addr_t  idx;
      int         n;
      seed     = 93;
      msoc_clk = 1'b0;
      rstn     = 1'b1;
      host_req = '0;
      dip      = '0;
      drv_rx   = 1'b1;
      loopback = 1'b0;
      #1;
      rstn = 1'b0;
      repeat (16) @(posedge msoc_clk);
      #1;
      rstn = 1'b1;

      // After reset
      check_byte("led_o", led, '0);
      check_bit("irq_o", irq, 1'b0);
      check_bit("uart_tx_o", uart_tx, 1'b1);
      baud_shadow = `PERIPH_BAUD_RESET;
      reg_read(`REG_BAUD, rd);
      check_word("REG_BAUD", rd, word_t'(baud_shadow));
      reg_read(`REG_UART_STAT, rd);
      check_word("REG_UART_STAT", rd, '0);
      reg_read(`REG_IRQ_STAT, rd);
      check_word("REG_IRQ_STAT", rd, 32'h4);      // Only transmitter idle
      repeat (4)
      begin
         reg_read({1'b1, 3'($random(seed))}, rd);
         check_word("unmapped register", rd, `PERIPH_UNMAPPED_WORD);
      end

      // Register readback and DIP sampling
      repeat (4)
      begin
         val = $random(seed);
         reg_write(`REG_LED, val);
         led_shadow = val[7:0];
         reg_read(`REG_LED, rd);
         check_word("REG_LED", rd, word_t'(led_shadow));
         check_byte("led_o", led, led_shadow);
         val = $random(seed);
         reg_write(`REG_BAUD, val);
         baud_shadow = val[15:0];
         reg_read(`REG_BAUD, rd);
         check_word("REG_BAUD", rd, word_t'(baud_shadow));
         val = $random(seed);
         reg_write(`REG_IRQ_EN, val);
         irq_en_shadow = val[2:0];
         reg_read(`REG_IRQ_EN, rd);
         check_word("REG_IRQ_EN", rd, word_t'(irq_en_shadow));
         dip        = dip_t'($random(seed));
         dip_shadow = dip;
         wait_cycles(2);
         reg_read(`REG_DIP, rd);
         check_word("REG_DIP", rd, word_t'(dip_shadow));
      end
      reg_write(`REG_DIP, $random(seed));         // Read-only, must not stick
      reg_read(`REG_DIP, rd);
      check_word("REG_DIP after write", rd, word_t'(dip_shadow));
      reg_write(`REG_IRQ_EN, '0);
      irq_en_shadow = '0;

      // Transfer RAM, reads pipelined with register reads
      repeat (64)
      begin
         idx = ram_addr_t'($random(seed));
         val = $random(seed);
         ram_write(idx, val);
         ram_model[idx] = val;
         written_q.push_back(idx);
      end
      repeat (32)
      begin
         idx = written_q[{$random(seed)} % written_q.size()];
         ram_read(idx, rd);
         check_word($sformatf("xfer_ram[%0d]", idx), rd, ram_model[idx]);
         reg_read(`REG_LED, rd);
         check_word("REG_LED between RAM reads", rd, word_t'(led_shadow));
      end

      // UART loopback
      loopback = 1'b1;
      reg_write(`REG_BAUD, word_t'(BAUD_TEST));
      baud_shadow = baud_t'(BAUD_TEST);
      reg_write(`REG_RX_ACK, '0);
      for (n = 0; n < 10; n++)
      begin
         b = byte_t'($random(seed));
         transmit_byte(b);
         wait_rx_flag(stat);
         check_bit("received", stat.received, 1'b1);
         check_bit("recv_err", stat.recv_err, 1'b0);
         check_byte("rx_byte", stat.rx_byte, b);
         reg_write(`REG_RX_ACK, '0);
         wait_cycles(1);                          // Ack pulse reaches the receiver
         read_stat(stat);
         check_bit("received after rx_ack", stat.received, 1'b0);
      end

      // Framing error from a driven frame
      wait_tx_idle();
      loopback = 1'b0;
      wait_cycles(4);
      b = byte_t'($random(seed));
      drive_frame(b, 1'b0);
      wait_rx_flag(stat);
      check_bit("recv_err", stat.recv_err, 1'b1);
      check_bit("received on bad frame", stat.received, 1'b0);
      check_byte("rx_byte on bad frame", stat.rx_byte, b);
      reg_write(`REG_RX_ACK, '0);
      wait_cycles(1);
      read_stat(stat);
      check_bit("recv_err after rx_ack", stat.recv_err, 1'b0);

      // Interrupt on received byte
      loopback = 1'b1;
      reg_write(`REG_IRQ_EN, 32'h1);
      wait_cycles(2);
      check_bit("irq_o with only rx irq enabled", irq, 1'b0);
      b = byte_t'($random(seed));
      transmit_byte(b);
      n = 0;
      while (irq !== 1'b1 && n < IRQ_WINDOW)
      begin
         wait_cycles(1);
         n++;
      end
      if (irq !== 1'b1)
         abort_run("irq_o did not rise after a byte was received");
      read_stat(stat);
      check_byte("rx_byte with irq", stat.rx_byte, b);
      reg_write(`REG_RX_ACK, '0);
      wait_cycles(3);
      check_bit("irq_o after rx_ack", irq, 1'b0);

      // Interrupt on transmitter idle
      reg_write(`REG_IRQ_EN, 32'h4);
      wait_cycles(2);
      check_bit("irq_o with transmitter idle", irq, 1'b1);
      b = byte_t'($random(seed));
      transmit_byte(b);
      read_stat(stat);
      while (!stat.is_trans)
         read_stat(stat);
      wait_cycles(2);
      check_bit("irq_o while transmitting", irq, 1'b0);
      wait_tx_idle();
      wait_cycles(2);
      check_bit("irq_o after frame", irq, 1'b1);
      wait_rx_flag(stat);
      check_byte("rx_byte idle irq frame", stat.rx_byte, b);
      reg_write(`REG_RX_ACK, '0);
      reg_write(`REG_IRQ_EN, '0);
      wait_cycles(2);

      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

//--- periph_soc.f
+incdir+common
common/periph_pkg.sv
logic/host_decode.sv
logic/ctrl_regs.sv
logic/xfer_ram.sv
uart/uart_tx.sv
uart/uart_rx.sv
logic/periph_soc.sv
verification/periph_soc_assertions.sv
verification/tb_periph_soc.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the peripheral testbench with Verilator, run it, then scan the log
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_periph_soc
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module "$TOP" --Mdir "$BUILD_DIR" -o "$TOP" -f periph_soc.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -qF "All tests passed!" "$LOG"; then
   echo "Simulation PASSED"
   exit 0
fi
echo "Simulation FAILED"
exit 1
